/* design/cube_draw_params.svh */
`ifndef CUBE_DRAW_PARAMS_SVH
`define CUBE_DRAW_PARAMS_SVH

// Frame buffer
`define SCREEN_W 160
`define SCREEN_H 120

`define X_W 8
`define Y_W 7

`define COLOUR_W 9          // 3 bits per channel
`define STICKER_ID_W 3

// Pass lengths in pixels
`define CLEAR_PIXELS (`SCREEN_W * `SCREEN_H)
`define CUBE_PIXELS 3456    // 54 stickers of 64 pixels

// Net geometry
`define CELL_PX 8
`define FACE_PX 24
`define STICKERS_PER_FACE 9

// Top-left corner of the 96 by 72 net
`define NET_X0 32
`define NET_Y0 24

`define COUNT_W 15

`endif

/* design/cube_draw_pkg.sv */
`include "cube_draw_params.svh"

package cube_draw_pkg;

    // Palette builds the word by channel, the frame buffer sees it raw
    typedef struct packed {
        logic [`COLOUR_W/3-1:0] red;
        logic [`COLOUR_W/3-1:0] green;
        logic [`COLOUR_W/3-1:0] blue;
    } pixel_rgb_t;

    typedef union packed {
        logic [`COLOUR_W-1:0] word;
        pixel_rgb_t rgb;
    } pixel_colour_t;

endpackage

/* design/draw_sequencer.sv */
`timescale 1ns/100ps
`include "cube_draw_params.svh"

module draw_sequencer (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          redraw,
    input  logic [`X_W-1:0]               layout_x,
    input  logic [`Y_W-1:0]               layout_y,
    input  cube_draw_pkg::pixel_colour_t  cube_colour,
    output logic [`COUNT_W-1:0]           pixel_count,
    output logic [`X_W-1:0]               x,
    output logic [`Y_W-1:0]               y,
    output cube_draw_pkg::pixel_colour_t  colour,
    output logic                          plot
);

    localparam int XW = `X_W;
    localparam int YW = `Y_W;

    localparam logic [1:0] ST_CLEAR = 2'd0;
    localparam logic [1:0] ST_CUBE  = 2'd1;
    localparam logic [1:0] ST_IDLE  = 2'd2;

    logic [1:0]    state;
    logic          in_cube;
    logic          pass_end;
    logic [XW-1:0] clear_x;
    logic [YW-1:0] clear_y;

    assign in_cube = (state == ST_CUBE);

    assign pass_end = in_cube ? (pixel_count == `CUBE_PIXELS - 1)
                              : (pixel_count == `CLEAR_PIXELS - 1);

    // Row-major sweep of the whole screen
    assign clear_x = XW'(pixel_count % `SCREEN_W);
    assign clear_y = YW'(pixel_count / `SCREEN_W);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state       <= ST_CLEAR;
            pixel_count <= '0;
            plot        <= 1'b0;
            x           <= '0;
            y           <= '0;
            colour      <= '0;
        end else begin
            case (state)
                ST_CLEAR, ST_CUBE: begin
                    plot <= 1'b1;
                    if (in_cube) begin
                        x      <= layout_x;
                        y      <= layout_y;
                        colour <= cube_colour;
                    end else begin
                        x      <= clear_x;
                        y      <= clear_y;
                        colour <= '0;  // Black
                    end
                    if (pass_end) begin
                        pixel_count <= '0;
                        state       <= in_cube ? ST_IDLE : ST_CUBE;
                    end else begin
                        pixel_count <= pixel_count + 1'b1;
                    end
                end
                ST_IDLE: begin
                    plot <= 1'b0;
                    if (redraw) begin
                        state       <= ST_CLEAR;
                        pixel_count <= '0;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                    plot  <= 1'b0;
                end
            endcase
        end
    end

endmodule

/* design/net_layout.sv */
`timescale 1ns/100ps
`include "cube_draw_params.svh"

module net_layout (
    input  logic [`COUNT_W-1:0]      pixel_count,
    input  logic [`STICKER_ID_W-1:0] f1 [0:`STICKERS_PER_FACE-1],
    input  logic [`STICKER_ID_W-1:0] f2 [0:`STICKERS_PER_FACE-1],
    input  logic [`STICKER_ID_W-1:0] f3 [0:`STICKERS_PER_FACE-1],
    input  logic [`STICKER_ID_W-1:0] f4 [0:`STICKERS_PER_FACE-1],
    input  logic [`STICKER_ID_W-1:0] f5 [0:`STICKERS_PER_FACE-1],
    input  logic [`STICKER_ID_W-1:0] f6 [0:`STICKERS_PER_FACE-1],
    output logic [`X_W-1:0]          layout_x,
    output logic [`Y_W-1:0]          layout_y,
    output logic [2:0]               face,
    output logic [3:0]               sticker,
    output logic [2:0]               local_x,
    output logic [2:0]               local_y,
    output logic [`STICKER_ID_W-1:0] sticker_id
);

    localparam int XW = `X_W;
    localparam int YW = `Y_W;
    localparam int CW = `COUNT_W;

    logic [CW-1:0] cell_num;
    logic [1:0]    sticker_col;
    logic [1:0]    sticker_row;
    logic [XW-1:0] origin_x;
    logic [YW-1:0] origin_y;

    // 64 pixels per sticker, row-major inside the cell
    assign cell_num = CW'(pixel_count / (`CELL_PX * `CELL_PX));
    assign local_x  = pixel_count[2:0];
    assign local_y  = pixel_count[5:3];

    assign face    = 3'(cell_num / `STICKERS_PER_FACE);
    assign sticker = 4'(cell_num % `STICKERS_PER_FACE);

    assign sticker_col = 2'(sticker % 3);
    assign sticker_row = 2'(sticker / 3);

    // Cross-shaped net, U on top and D below F
    always_comb begin
        case (face)
            3'd0: begin
                origin_x = XW'(`NET_X0 + `FACE_PX);
                origin_y = YW'(`NET_Y0);
            end
            3'd1: begin
                origin_x = XW'(`NET_X0);
                origin_y = YW'(`NET_Y0 + `FACE_PX);
            end
            3'd2: begin
                origin_x = XW'(`NET_X0 + `FACE_PX);
                origin_y = YW'(`NET_Y0 + `FACE_PX);
            end
            3'd3: begin
                origin_x = XW'(`NET_X0 + 2 * `FACE_PX);
                origin_y = YW'(`NET_Y0 + `FACE_PX);
            end
            3'd4: begin
                origin_x = XW'(`NET_X0 + 3 * `FACE_PX);
                origin_y = YW'(`NET_Y0 + `FACE_PX);
            end
            default: begin
                origin_x = XW'(`NET_X0 + `FACE_PX);
                origin_y = YW'(`NET_Y0 + 2 * `FACE_PX);
            end
        endcase
    end

    assign layout_x = XW'(origin_x + sticker_col * `CELL_PX + local_x);
    assign layout_y = YW'(origin_y + sticker_row * `CELL_PX + local_y);

    always_comb begin
        case (face)
            3'd0:    sticker_id = f5[sticker];
            3'd1:    sticker_id = f3[sticker];
            3'd2:    sticker_id = f1[sticker];
            3'd3:    sticker_id = f4[sticker];
            3'd4:    sticker_id = f2[sticker];
            default: sticker_id = f6[sticker];
        endcase
    end

endmodule

/* design/centre_letter_rom.sv */
`timescale 1ns/100ps

module centre_letter_rom (
    input  logic [2:0] face,
    input  logic [3:0] sticker,
    input  logic [2:0] local_x,
    input  logic [2:0] local_y,
    output logic       letter_on
);

    // Five rows of three pixels, top row in the high bits, left pixel first
    localparam logic [14:0] GLYPH_U = 15'b101_101_101_101_111;
    localparam logic [14:0] GLYPH_L = 15'b100_100_100_100_111;
    localparam logic [14:0] GLYPH_F = 15'b111_100_111_100_100;
    localparam logic [14:0] GLYPH_R = 15'b110_101_110_110_101;
    localparam logic [14:0] GLYPH_B = 15'b110_101_110_101_110;
    localparam logic [14:0] GLYPH_D = 15'b110_101_101_101_110;

    logic [2:0]  letter_x;
    logic [2:0]  letter_y;
    logic [14:0] glyph;
    logic [2:0]  glyph_row;
    logic        glyph_bit;

    // Letter window starts two pixels in; wraps below zero fall outside
    assign letter_x = local_x - 3'd2;
    assign letter_y = local_y - 3'd2;

    always_comb begin
        case (face)
            3'd0:    glyph = GLYPH_U;
            3'd1:    glyph = GLYPH_L;
            3'd2:    glyph = GLYPH_F;
            3'd3:    glyph = GLYPH_R;
            3'd4:    glyph = GLYPH_B;
            default: glyph = GLYPH_D;
        endcase
        case (letter_y)
            3'd0:    glyph_row = glyph[14:12];
            3'd1:    glyph_row = glyph[11:9];
            3'd2:    glyph_row = glyph[8:6];
            3'd3:    glyph_row = glyph[5:3];
            3'd4:    glyph_row = glyph[2:0];
            default: glyph_row = 3'b000;
        endcase
        case (letter_x)
            3'd0:    glyph_bit = glyph_row[2];
            3'd1:    glyph_bit = glyph_row[1];
            3'd2:    glyph_bit = glyph_row[0];
            default: glyph_bit = 1'b0;
        endcase
    end

    assign letter_on = (sticker == 4'd4) && glyph_bit;  // Centre only

endmodule

/* design/sticker_shader.sv */
`timescale 1ns/100ps
`include "cube_draw_params.svh"

module sticker_shader (
    input  logic [2:0]                   local_x,
    input  logic [2:0]                   local_y,
    input  logic                         letter_on,
    input  logic [`STICKER_ID_W-1:0]     sticker_id,
    output cube_draw_pkg::pixel_colour_t cube_colour
);

    logic                         on_frame;
    cube_draw_pkg::pixel_colour_t palette;

    assign on_frame = (local_x == 3'd0) || (local_x == 3'd7) ||
                      (local_y == 3'd0) || (local_y == 3'd7);

    always_comb begin
        palette.word = '0;
        case (sticker_id)
            3'd0: palette.rgb = '{red: 3'b111, green: 3'b111, blue: 3'b111};  // White
            3'd1: palette.rgb = '{red: 3'b111, green: 3'b111, blue: 3'b000};  // Yellow
            3'd2: palette.rgb = '{red: 3'b000, green: 3'b000, blue: 3'b111};  // Blue
            3'd3: palette.rgb = '{red: 3'b000, green: 3'b111, blue: 3'b000};  // Green
            3'd4: palette.rgb = '{red: 3'b111, green: 3'b000, blue: 3'b000};  // Red
            3'd5: palette.rgb = '{red: 3'b111, green: 3'b000, blue: 3'b111};  // Magenta
            default: palette.word = '0;  // Unused ids stay black
        endcase
    end

    // Frame wins over the letter, letter over the sticker colour
    always_comb begin
        if (on_frame || letter_on) begin
            cube_colour.word = '0;
        end else begin
            cube_colour = palette;
        end
    end

endmodule

/* design/cube_drawer.sv */
`timescale 1ns/100ps
`include "cube_draw_params.svh"

module cube_drawer (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          redraw,
    input  logic [`STICKER_ID_W-1:0]      f1 [0:`STICKERS_PER_FACE-1],
    input  logic [`STICKER_ID_W-1:0]      f2 [0:`STICKERS_PER_FACE-1],
    input  logic [`STICKER_ID_W-1:0]      f3 [0:`STICKERS_PER_FACE-1],
    input  logic [`STICKER_ID_W-1:0]      f4 [0:`STICKERS_PER_FACE-1],
    input  logic [`STICKER_ID_W-1:0]      f5 [0:`STICKERS_PER_FACE-1],
    input  logic [`STICKER_ID_W-1:0]      f6 [0:`STICKERS_PER_FACE-1],
    output logic [`X_W-1:0]               x,
    output logic [`Y_W-1:0]               y,
    output cube_draw_pkg::pixel_colour_t  colour,
    output logic                          plot
);

    logic [`COUNT_W-1:0]          pixel_count;
    logic [`X_W-1:0]              layout_x;
    logic [`Y_W-1:0]              layout_y;
    logic [2:0]                   face;
    logic [3:0]                   sticker;
    logic [2:0]                   local_x;
    logic [2:0]                   local_y;
    logic [`STICKER_ID_W-1:0]     sticker_id;
    logic                         letter_on;
    cube_draw_pkg::pixel_colour_t cube_colour;

    draw_sequencer u_seq (
        .clk(clk), .resetn(resetn), .redraw(redraw),
        .layout_x(layout_x), .layout_y(layout_y), .cube_colour(cube_colour),
        .pixel_count(pixel_count), .x(x), .y(y), .colour(colour), .plot(plot)
    );

    net_layout u_layout (
        .pixel_count(pixel_count),
        .f1(f1), .f2(f2), .f3(f3), .f4(f4), .f5(f5), .f6(f6),
        .layout_x(layout_x), .layout_y(layout_y), .face(face), .sticker(sticker),
        .local_x(local_x), .local_y(local_y), .sticker_id(sticker_id)
    );

    centre_letter_rom u_letter (
        .face(face), .sticker(sticker), .local_x(local_x), .local_y(local_y),
        .letter_on(letter_on)
    );

    sticker_shader u_shader (
        .local_x(local_x), .local_y(local_y), .letter_on(letter_on),
        .sticker_id(sticker_id), .cube_colour(cube_colour)
    );

endmodule

/* sim/cube_drawer_tb.sv */
`timescale 1ns/100ps
`include "cube_draw_params.svh"

module cube_drawer_tb;

    localparam int XW          = `X_W;
    localparam int YW          = `Y_W;
    localparam int CLK_PERIOD  = 20;
    localparam int DRAW_CYCLES = `CLEAR_PIXELS + `CUBE_PIXELS;
    localparam int WATCHDOG_NS = (3 * DRAW_CYCLES + 200) * CLK_PERIOD;  // Three draws plus margin
    localparam int EXP_W       = `X_W + `Y_W + `COLOUR_W;

    logic                         clk;
    logic                         resetn;
    logic                         redraw;
    logic [`STICKER_ID_W-1:0]     f1 [0:`STICKERS_PER_FACE-1];
    logic [`STICKER_ID_W-1:0]     f2 [0:`STICKERS_PER_FACE-1];
    logic [`STICKER_ID_W-1:0]     f3 [0:`STICKERS_PER_FACE-1];
    logic [`STICKER_ID_W-1:0]     f4 [0:`STICKERS_PER_FACE-1];
    logic [`STICKER_ID_W-1:0]     f5 [0:`STICKERS_PER_FACE-1];
    logic [`STICKER_ID_W-1:0]     f6 [0:`STICKERS_PER_FACE-1];
    logic [`X_W-1:0]              x;
    logic [`Y_W-1:0]              y;
    cube_draw_pkg::pixel_colour_t colour;
    logic                         plot;

    int mismatch_errors = 0;
    int other_errors    = 0;
    int write_idx       = 0;
    int draws_done      = 0;
    bit draw_armed      = 1'b1;  // Reset starts a draw by itself

    cube_drawer dut0 (
        .clk(clk), .resetn(resetn), .redraw(redraw),
        .f1(f1), .f2(f2), .f3(f3), .f4(f4), .f5(f5), .f6(f6),
        .x(x), .y(y), .colour(colour), .plot(plot)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Net faces in draw order U L F R B D take their ids from f5 f3 f1 f4 f2 f6
    function automatic logic [`STICKER_ID_W-1:0] face_id(input int face, input int s);
        case (face)
            0:       return f5[s];
            1:       return f3[s];
            2:       return f1[s];
            3:       return f4[s];
            4:       return f2[s];
            default: return f6[s];
        endcase
    endfunction

    function automatic cube_draw_pkg::pixel_colour_t palette(input logic [2:0] id);
        cube_draw_pkg::pixel_colour_t c;
        case (id)
            3'd0:    c.word = 9'b111111111;
            3'd1:    c.word = 9'b111111000;
            3'd2:    c.word = 9'b000000111;
            3'd3:    c.word = 9'b000111000;
            3'd4:    c.word = 9'b111000000;
            3'd5:    c.word = 9'b111000111;
            default: c.word = 9'b000000000;
        endcase
        return c;
    endfunction

    // Rows top to bottom with the leftmost pixel in the high bit
    function automatic logic [14:0] face_letter(input int face);
        case (face)
            0:       return {3'b101, 3'b101, 3'b101, 3'b101, 3'b111};  // U
            1:       return {3'b100, 3'b100, 3'b100, 3'b100, 3'b111};  // L
            2:       return {3'b111, 3'b100, 3'b111, 3'b100, 3'b100};  // F
            3:       return {3'b110, 3'b101, 3'b110, 3'b110, 3'b101};  // R
            4:       return {3'b110, 3'b101, 3'b110, 3'b101, 3'b110};  // B
            default: return {3'b110, 3'b101, 3'b101, 3'b101, 3'b110};  // D
        endcase
    endfunction

    // Expected {x, y, colour} of write idx within a pass
    function automatic logic [EXP_W-1:0] expected_write(input bit cube_pass, input int idx);
        int sticker_num;
        int lx;
        int ly;
        int face;
        int s;
        int ox;
        int oy;
        int gx;
        int gy;
        bit letter;
        logic [14:0] glyph;
        cube_draw_pkg::pixel_colour_t c;
        if (!cube_pass) begin
            c.word = '0;
            return {XW'(idx % `SCREEN_W), YW'(idx / `SCREEN_W), c.word};
        end
        sticker_num = idx / 64;
        lx   = idx % 8;
        ly   = (idx / 8) % 8;
        face = sticker_num / 9;
        s    = sticker_num % 9;
        case (face)
            0, 2, 5: ox = `NET_X0 + `FACE_PX;
            1:       ox = `NET_X0;
            3:       ox = `NET_X0 + 2 * `FACE_PX;
            default: ox = `NET_X0 + 3 * `FACE_PX;
        endcase
        case (face)
            0:       oy = `NET_Y0;
            5:       oy = `NET_Y0 + 2 * `FACE_PX;
            default: oy = `NET_Y0 + `FACE_PX;
        endcase
        gx     = lx - 2;
        gy     = ly - 2;
        glyph  = face_letter(face);
        letter = (s == 4) && gx >= 0 && gx < 3 && gy >= 0 && gy < 5 && glyph[14 - gy * 3 - gx];
        if (lx == 0 || lx == 7 || ly == 0 || ly == 7 || letter)
            c.word = '0;
        else
            c = palette(face_id(face, s));
        return {XW'(ox + (s % 3) * 8 + lx), YW'(oy + (s / 3) * 8 + ly), c.word};
    endfunction

    task automatic compare_coord(input string name,
                                 input logic [`X_W-1:0] exp_x, input logic [`Y_W-1:0] exp_y,
                                 input logic [`X_W-1:0] act_x, input logic [`Y_W-1:0] act_y);
        if (exp_x !== act_x || exp_y !== act_y) begin
            mismatch_errors++;
            $display("Mismatch %s position: expected (%0d,%0d), actual (%0d,%0d)",
                     name, exp_x, exp_y, act_x, act_y);
        end
    endtask

    task automatic compare_colour(input string name,
                                  input cube_draw_pkg::pixel_colour_t exp_c,
                                  input cube_draw_pkg::pixel_colour_t act_c);
        if (exp_c.word !== act_c.word) begin
            mismatch_errors++;
            $display("Mismatch %s colour: expected %b, actual %b", name, exp_c.word, act_c.word);
        end
    endtask

    task automatic set_face(input int k, input int s, input logic [`STICKER_ID_W-1:0] id);
        case (k)
            0:       f1[s] = id;
            1:       f2[s] = id;
            2:       f3[s] = id;
            3:       f4[s] = id;
            4:       f5[s] = id;
            default: f6[s] = id;
        endcase
    endtask

    // Walks ids 0 to 7 so every palette entry shows up
    task automatic load_sweep_faces();
        for (int k = 0; k < 6; k++)
            for (int s = 0; s < `STICKERS_PER_FACE; s++)
                set_face(k, s, 3'((k * 9 + s) % 8));
    endtask

    task automatic load_random_faces();
        for (int k = 0; k < 6; k++)
            for (int s = 0; s < `STICKERS_PER_FACE; s++)
                set_face(k, s, 3'($urandom_range(7, 0)));
    endtask

    task automatic pulse_redraw();
        redraw     = 1'b1;
        draw_armed = 1'b1;
        @(posedge clk);
        #2 redraw = 1'b0;
    endtask

    // Checks each write on the falling edge
    logic [EXP_W-1:0]             exp_word;
    cube_draw_pkg::pixel_colour_t exp_colour;
    bit                           in_cube;
    int                           pass_idx;
    always @(negedge clk) begin
        if (plot) begin
            if (!draw_armed) begin
                other_errors++;
                $display("Error: plot is high while the drawer should be idle at %0t", $time);
            end else if (write_idx >= DRAW_CYCLES) begin
                other_errors++;
                $display("Error: draw %0d wrote more than %0d pixels", draws_done + 1,
                         DRAW_CYCLES);
            end else begin
                in_cube  = write_idx >= `CLEAR_PIXELS;
                pass_idx = in_cube ? write_idx - `CLEAR_PIXELS : write_idx;
                exp_word = expected_write(in_cube, pass_idx);
                exp_colour.word = exp_word[`COLOUR_W-1:0];
                compare_coord($sformatf("draw%0d %s pixel %0d", draws_done + 1,
                                        in_cube ? "cube" : "clear", pass_idx),
                              exp_word[EXP_W-1 -: XW], exp_word[`COLOUR_W +: YW], x, y);
                compare_colour($sformatf("draw%0d %s pixel %0d", draws_done + 1,
                                         in_cube ? "cube" : "clear", pass_idx),
                               exp_colour, colour);
            end
            write_idx++;
        end else if (write_idx != 0) begin
            if (write_idx != DRAW_CYCLES) begin
                other_errors++;
                $display("Error: draw %0d made %0d writes in a row instead of %0d",
                         draws_done + 1, write_idx, DRAW_CYCLES);
            end
            write_idx  = 0;
            draw_armed = 1'b0;
            draws_done++;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        other_errors++;
        $display("Timeout: drawing did not finish within %0d ns", WATCHDOG_NS);
        $display("Errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        int seed_value;
        seed_value = $urandom(28);
        resetn = 1'b0;
        redraw = 1'b0;
        load_sweep_faces();
        repeat (10) @(posedge clk);
        #2 resetn = 1'b1;

        wait (draws_done == 1);
        repeat (20) @(posedge clk);  // Plot must stay low while idle
        #2 load_random_faces();
        pulse_redraw();

        wait (draws_done == 2);
        repeat (20) @(posedge clk);
        #2 load_random_faces();
        pulse_redraw();
        repeat (5000) @(posedge clk);  // Lands in the middle of the clear pass
        #2 pulse_redraw();

        wait (draws_done == 3);
        repeat (20) @(posedge clk);
        $display("Errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+design
design/cube_draw_pkg.sv
design/draw_sequencer.sv
design/net_layout.sv
design/centre_letter_rom.sv
design/sticker_shader.sv
design/cube_drawer.sv
sim/cube_drawer_tb.sv
